/* source/fbPkg.sv */
// Shared types and helpers for the double-buffered frame buffer.
// Pixel and address words, RGB565 expansion, and the base address of
// either buffer half. Referenced by scoped name from every design file.

package fbPkg;

	typedef logic [15:0] pixelT;     // rgb565 word as stored in sram
	typedef logic [19:0] sramAddrT;  // sram word address

	// scanout colour, one byte per channel
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888T;

	// widen 5/6/5 fields, low bits left at zero
	function automatic rgb888T expandRgb(input pixelT pix);
		rgb888T rgb;
		rgb.red   = {pix[4:0], 3'b000};   // red sits in the low field
		rgb.green = {pix[10:5], 2'b00};
		rgb.blue  = {pix[15:11], 3'b000}; // blue in the top field
		return rgb;
	endfunction

	// buffer 1 starts right after one full frame
	function automatic sramAddrT bufferBase(
		input logic        sel,
		input int unsigned frameWidth,
		input int unsigned frameHeight
	);
		sramAddrT base;
		base = sel ? sramAddrT'(frameWidth * frameHeight) : '0;
		return base;
	endfunction

endpackage

/* source/frameBuffer.sv */
// Top level of the tile frame buffer. Connects scanout and the tile
// streamer to the SRAM arbiter and brings the SRAM pins out as plain
// ports. Frame and tile sizes are set here and passed down.

`timescale 1ns/1ps

module frameBuffer #(
	parameter int frameWidth  = 800,
	parameter int frameHeight = 525,
	parameter int tileDim     = 8
) (
	input  logic            BOARD_CLK,
	input  logic            rstN,
	// scan side
	input  logic [9:0]      scanX,
	input  logic [9:0]      scanY,
	input  logic            pixelEn,
	input  logic            blankN,
	input  logic            doubleBuffer,
	// tile side
	input  logic            trigger,
	input  logic [9:0]      xOffset,
	input  logic [9:0]      yOffset,
	input  fbPkg::pixelT    tilePixel,
	output logic [7:0]      tileX,
	output logic [7:0]      tileY,
	// video out
	output logic [7:0]      red,
	output logic [7:0]      green,
	output logic [7:0]      blue,
	output logic            rgbValid,
	output logic            doneStreaming,
	output logic            busy,
	// sram pins
	output fbPkg::sramAddrT sramAddr,
	output logic            sramWeN,
	output logic            sramCeN,
	output logic            sramOeN,
	output logic            sramUbN,
	output logic            sramLbN,
	inout  wire [15:0]      sramDq
);

	sramPort scanBus ();  // scanout reads
	sramPort tileBus ();  // tile writes

	scanoutReader #(
		.frameWidth  (frameWidth),
		.frameHeight (frameHeight)
	) scanout (
		.BOARD_CLK    (BOARD_CLK),
		.rstN         (rstN),
		.scanX        (scanX),
		.scanY        (scanY),
		.pixelEn      (pixelEn),
		.blankN       (blankN),
		.doubleBuffer (doubleBuffer),
		.port         (scanBus.client),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.rgbValid     (rgbValid)
	);

	tileStreamer #(
		.frameWidth  (frameWidth),
		.frameHeight (frameHeight),
		.tileDim     (tileDim)
	) streamer (
		.BOARD_CLK     (BOARD_CLK),
		.rstN          (rstN),
		.trigger       (trigger),
		.xOffset       (xOffset),
		.yOffset       (yOffset),
		.doubleBuffer  (doubleBuffer),
		.tilePixel     (tilePixel),
		.port          (tileBus.client),
		.tileX         (tileX),
		.tileY         (tileY),
		.doneStreaming (doneStreaming),
		.busy          (busy)
	);

	sramArbiter arbiter (
		.BOARD_CLK (BOARD_CLK),
		.rstN      (rstN),
		.scanPort  (scanBus.arbiter),
		.tilePort  (tileBus.arbiter),
		.sramAddr  (sramAddr),
		.sramWeN   (sramWeN),
		.sramCeN   (sramCeN),
		.sramOeN   (sramOeN),
		.sramUbN   (sramUbN),
		.sramLbN   (sramLbN),
		.sramDq    (sramDq)
	);

endmodule

/* source/scanoutReader.sv */
// Front-buffer scanout. Every pixel strobe during active video issues
// one SRAM read; the returned RGB565 word is expanded to 8-bit channels
// and presented with an rgbValid pulse.

`timescale 1ns/1ps

module scanoutReader #(
	parameter int frameWidth  = 800,
	parameter int frameHeight = 525
) (
	input  logic        BOARD_CLK,
	input  logic        rstN,
	input  logic [9:0]  scanX,
	input  logic [9:0]  scanY,
	input  logic        pixelEn,       // pixel strobe, never two in a row
	input  logic        blankN,        // active video when high
	input  logic        doubleBuffer,  // front buffer select
	sramPort.client     port,
	output logic [7:0]  red,
	output logic [7:0]  green,
	output logic [7:0]  blue,
	output logic        rgbValid
);

	logic          readIssued;  // read granted last cycle
	logic          wordReady;   // rdata holds the word now
	fbPkg::rgb888T rgb;

	// only fetch while video is active
	assign port.req   = pixelEn & blankN;
	assign port.we    = 1'b0;             // reads only
	assign port.wdata = '0;

	// linear address into the front half
	assign port.addr = fbPkg::sramAddrT'(scanX)
		+ fbPkg::sramAddrT'(scanY) * fbPkg::sramAddrT'(frameWidth)
		+ fbPkg::bufferBase(doubleBuffer, frameWidth, frameHeight);

	// valid shift, follows the arbiter pipe
	always_ff @(posedge BOARD_CLK or negedge rstN) begin
		if (!rstN) begin
			readIssued <= 1'b0;
			wordReady  <= 1'b0;
			rgbValid   <= 1'b0;
			rgb        <= '0;
		end else begin
			readIssued <= port.req & port.grant;
			wordReady  <= readIssued;  // sram word captured at this edge
			rgbValid   <= wordReady;
			if (wordReady)
				rgb <= fbPkg::expandRgb(port.rdata);  // hold colour between pixels
		end
	end

	assign red   = rgb.red;
	assign green = rgb.green;
	assign blue  = rgb.blue;

	// scanout has top priority, so never stalls and never fetches in blanking
	assert property (@(posedge BOARD_CLK) disable iff (!rstN)
		port.req |-> blankN && port.grant);

	// fixed pipeline depth from strobe to colour
	assert property (@(posedge BOARD_CLK) disable iff (!rstN)
		port.req |-> ##3 rgbValid);

endmodule

/* source/sramArbiter.sv */
// Shares the single-port SRAM between scanout and the tile streamer.
// Scanout has fixed priority; the streamer takes every other cycle.
// Address, write strobe and write data are registered onto the pins,
// and read data is captured one cycle later into rdata.

`timescale 1ns/1ps

module sramArbiter (
	input  logic            BOARD_CLK,
	input  logic            rstN,
	sramPort.arbiter        scanPort,
	sramPort.arbiter        tilePort,
	output fbPkg::sramAddrT sramAddr,
	output logic            sramWeN,
	output logic            sramCeN,
	output logic            sramOeN,
	output logic            sramUbN,
	output logic            sramLbN,
	inout  wire [15:0]      sramDq
);

	logic         scanGrant, tileGrant;
	logic         readPending;  // pins hold a read address this cycle
	fbPkg::pixelT dataOut;      // write data register
	fbPkg::pixelT rdata;

	// fixed priority, streamer fills the gaps
	assign scanGrant = scanPort.req;
	assign tileGrant = tilePort.req & ~scanPort.req;

	assign scanPort.grant = scanGrant;
	assign tilePort.grant = tileGrant;

	// control side of the pins
	always_ff @(posedge BOARD_CLK or negedge rstN) begin
		if (!rstN) begin
			sramWeN     <= 1'b1;
			readPending <= 1'b0;
		end else begin
			if (scanGrant) begin
				sramWeN     <= ~scanPort.we;
				readPending <= ~scanPort.we;
			end else if (tileGrant) begin
				sramWeN     <= ~tilePort.we;
				readPending <= ~tilePort.we;
			end else begin
				sramWeN     <= 1'b1;  // idle cycle, no stray write
				readPending <= 1'b0;
			end
		end
	end

	// address and data follow the granted client
	always_ff @(posedge BOARD_CLK) begin
		if (scanGrant) begin
			sramAddr <= scanPort.addr;
			dataOut  <= scanPort.wdata;
		end else if (tileGrant) begin
			sramAddr <= tilePort.addr;
			dataOut  <= tilePort.wdata;
		end
		if (readPending)
			rdata <= sramDq;  // async sram has settled by now
	end

	assign scanPort.rdata = rdata;  // shared return bus
	assign tilePort.rdata = rdata;

	// drive the bus only during writes
	assign sramDq = sramWeN ? 16'bz : dataOut;

	// chip always selected, both bytes, outputs on
	assign sramCeN = 1'b0;
	assign sramOeN = 1'b0;
	assign sramUbN = 1'b0;
	assign sramLbN = 1'b0;

	assert property (@(posedge BOARD_CLK) disable iff (!rstN)
		!(scanPort.grant && tilePort.grant));

	// granted write lands on the bus one cycle later
	assert property (@(posedge BOARD_CLK) disable iff (!rstN)
		tilePort.grant && tilePort.we |=> !sramWeN && sramDq == $past(tilePort.wdata));

endmodule

/* source/sramPort.sv */
// Request channel from one frame buffer client to the SRAM arbiter.
// Client holds req with addr/we/wdata stable until grant is seen high;
// read data comes back on rdata after the grant.

`timescale 1ns/1ps

interface sramPort;

	logic             req;    // client wants a cycle
	logic             we;     // 1 = write, 0 = read
	fbPkg::sramAddrT  addr;
	fbPkg::pixelT     wdata;
	logic             grant;  // transfer completes in this cycle
	fbPkg::pixelT     rdata;  // captured read word

	modport client (
		output req,
		output we,
		output addr,
		output wdata,
		input  grant,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output grant,
		output rdata
	);

endinterface

/* source/tileStreamer.sv */
// Copies a tileDim x tileDim block from the external tile source into the
// back buffer. A trigger while idle latches the offsets; each granted write
// advances the tile pointer, x first, and doneStreaming pulses at the end.

`timescale 1ns/1ps

module tileStreamer #(
	parameter int frameWidth  = 800,
	parameter int frameHeight = 525,
	parameter int tileDim     = 8
) (
	input  logic         BOARD_CLK,
	input  logic         rstN,
	input  logic         trigger,       // start strobe, ignored while busy
	input  logic [9:0]   xOffset,
	input  logic [9:0]   yOffset,
	input  logic         doubleBuffer,
	input  fbPkg::pixelT tilePixel,     // from tile source, combinational
	sramPort.client      port,
	output logic [7:0]   tileX,
	output logic [7:0]   tileY,
	output logic         doneStreaming,
	output logic         busy
);

	enum logic {stIdle, stStream} state;

	logic [9:0] xOff, yOff;    // latched at trigger
	logic       backSel;       // back buffer half for this tile
	logic [7:0] ptrX, ptrY;    // position inside the tile
	logic       lastPixel;

	assign lastPixel = (ptrX == 8'(tileDim - 1)) && (ptrY == 8'(tileDim - 1));

	always_ff @(posedge BOARD_CLK or negedge rstN) begin
		if (!rstN) begin
			state         <= stIdle;
			doneStreaming <= 1'b0;
			ptrX          <= '0;
			ptrY          <= '0;
		end else begin
			doneStreaming <= 1'b0;  // one cycle pulse
			case (state)
				stIdle: begin
					ptrX <= '0;
					ptrY <= '0;
					if (trigger)
						state <= stStream;
				end
				stStream: begin
					if (port.grant) begin
						if (lastPixel) begin
							state         <= stIdle;
							doneStreaming <= 1'b1;
							ptrX          <= '0;
							ptrY          <= '0;
						end else if (ptrX == 8'(tileDim - 1)) begin
							ptrX <= '0;           // wrap to next row
							ptrY <= ptrY + 8'd1;
						end else begin
							ptrX <= ptrX + 8'd1;
						end
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// tile setup, only taken when a new tile starts
	always_ff @(posedge BOARD_CLK) begin
		if (state == stIdle && trigger) begin
			xOff    <= xOffset;
			yOff    <= yOffset;
			backSel <= ~doubleBuffer;  // draw into the hidden half
		end
	end

	assign busy = (state == stStream);

	assign tileX = ptrX;  // tile source looks up this pixel
	assign tileY = ptrY;

	assign port.req   = busy;
	assign port.we    = 1'b1;
	assign port.wdata = tilePixel;
	assign port.addr  = fbPkg::sramAddrT'(xOff) + fbPkg::sramAddrT'(ptrX)
		+ (fbPkg::sramAddrT'(yOff) + fbPkg::sramAddrT'(ptrY))
			* fbPkg::sramAddrT'(frameWidth)
		+ fbPkg::bufferBase(backSel, frameWidth, frameHeight);

	assert property (@(posedge BOARD_CLK) disable iff (!rstN)
		ptrX < tileDim && ptrY < tileDim);

	// final write granted, request gone and done flagged next cycle
	assert property (@(posedge BOARD_CLK) disable iff (!rstN)
		port.grant && lastPixel |=> !port.req && doneStreaming);

endmodule

/* test/clockGen.sv */
// Board clock and power-on reset for the frame buffer testbench.
// Clock toggles every half period; rstN is released on a falling edge.

`timescale 1ns/1ps

module clockGen #(
	parameter int periodNs    = 100,
	parameter int resetCycles = 10
) (
	output logic BOARD_CLK,
	output logic rstN
);

	initial begin
		BOARD_CLK = 1'b0;
		forever #(periodNs / 2) BOARD_CLK = ~BOARD_CLK;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge BOARD_CLK);
		@(negedge BOARD_CLK);
		rstN = 1'b1;  // away from the active edge
	end

endmodule

/* test/fbStim.txt */
# opcode xOffset yOffset seed(hex), tile/busytrig write the back buffer
# scan with a nonzero seed also starts a tile at the offsets with its first strobe
scan 0 0 0000
tile 2 3 1000
swap 0 0 0000
scan 0 0 0000
scan 6 4 2a00
busytrig 8 2 3300
tile 12 8 4400
tile 0 8 5500
tile 12 0 6600
swap 0 0 0000
scan 0 0 0000
swap 0 0 0000
scan 0 0 0000

/* test/frameBufferTb.sv */
// Testbench for the tile frame buffer. Commands come from test/fbStim.txt;
// a shadow copy of both SRAM halves gives the expected scanout colours.
// Inputs change on falling edges, outputs are checked there too.

`timescale 1ns/1ps

module frameBufferTb;

	localparam int frameWidth  = 16;
	localparam int frameHeight = 12;
	localparam int tileDim     = 4;
	localparam int frameWords  = frameWidth * frameHeight;

	logic        BOARD_CLK, rstN;
	logic [9:0]  scanX, scanY, xOffset, yOffset;
	logic        pixelEn, blankN, doubleBuffer, trigger;
	logic [15:0] tilePixel;
	logic [15:0] tileSeed;  // seed of the tile being copied
	logic [7:0]  tileX, tileY, red, green, blue;
	logic        rgbValid, doneStreaming, busy;
	logic [19:0] sramAddr;
	logic        sramWeN, sramCeN, sramOeN, sramUbN, sramLbN;
	wire  [15:0] sramDq;

	logic [15:0] shadow [0:2*frameWords-1];  // both buffers
	logic [23:0] expQ[$];                    // expected {r,g,b} per strobe
	int          edgeQ[$];                   // edge that sampled the strobe
	string       opQ[$];
	int          xQ[$], yQ[$];
	logic [15:0] seedQ[$];
	int          errors = 0, cycles = 0, cycleLimit = 0, doneCount = 0;
	int          testsRun = 0, testsFailed = 0;
	integer      seedVar = 32'ha581_c20a;
	logic [23:0] expRgb;
	int          expEdge;

	// external tile source: seed + row * 16 + column
	function automatic logic [15:0] tileSource(input logic [15:0] seed,
		input logic [7:0] tx, input logic [7:0] ty);
		return seed + 16'(ty) * 16'd16 + 16'(tx);
	endfunction

	// 5/6/5 fields scaled up to bytes
	function automatic logic [23:0] expectRgb(input logic [15:0] pix);
		int r, g, b;
		r = (pix % 32) * 8;          // low field is red
		g = ((pix / 32) % 64) * 4;
		b = (pix / 2048) * 8;        // top field is blue
		return {r[7:0], g[7:0], b[7:0]};
	endfunction

	function automatic int bufferStart(input logic sel);
		return sel ? frameWords : 0;
	endfunction

	// preload pattern, every address bit matters
	function automatic logic [15:0] fillWord(input logic [19:0] a);
		return (a[15:0] * 16'h9e37) ^ a[19:4];
	endfunction

	clockGen #(.periodNs(100), .resetCycles(10)) clkGen (.BOARD_CLK(BOARD_CLK), .rstN(rstN));

	frameBuffer #(
		.frameWidth  (frameWidth),
		.frameHeight (frameHeight),
		.tileDim     (tileDim)
	) uut (.*);

	sramModel #(.depth(2 * frameWords)) sram (
		.addr (sramAddr),
		.dq   (sramDq),
		.weN  (sramWeN),
		.ceN  (sramCeN),
		.oeN  (sramOeN)
	);

	assign tilePixel = tileSource(tileSeed, tileX, tileY);

	// edge counter, done pulses and run limit
	always @(posedge BOARD_CLK) begin
		cycles = cycles + 1;
		if (doneStreaming === 1'b1)
			doneCount = doneCount + 1;  // value from before this edge
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("run stopped after %0d cycles without finishing", cycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR %s: expected 0x%h got 0x%h", name, expected, actual);
		errors = errors + 1;
	endtask

	// every colour pulse matched against the oldest strobe
	always @(negedge BOARD_CLK) begin
		if (rstN === 1'b1 && rgbValid === 1'b1) begin
			if (expQ.size() == 0) begin
				$display("rgbValid pulsed with no pixel strobe outstanding");
				errors = errors + 1;
			end else begin
				expRgb  = expQ.pop_front();
				expEdge = edgeQ.pop_front();
				if (cycles != expEdge + 2)
					reportMismatch("rgbValid edge", expEdge + 2, cycles);
				if (red !== expRgb[23:16])
					reportMismatch("red", expRgb[23:16], red);
				if (green !== expRgb[15:8])
					reportMismatch("green", expRgb[15:8], green);
				if (blue !== expRgb[7:0])
					reportMismatch("blue", expRgb[7:0], blue);
			end
		end
	end

	task automatic commitTile(input int x, input int y, input logic [15:0] seed,
		input logic sel);
		for (int ty = 0; ty < tileDim; ty++)
			for (int tx = 0; tx < tileDim; tx++)
				shadow[bufferStart(sel) + (y + ty) * frameWidth + x + tx] =
					tileSource(seed, 8'(tx), 8'(ty));
	endtask

	// wait for the end of a tile, then make sure it pulsed once
	task automatic waitDone(input int startDone);
		int waited;
		waited = 0;
		while (doneCount == startDone && waited < 4 * tileDim * tileDim + 20) begin
			@(negedge BOARD_CLK);
			waited++;
		end
		if (doneCount == startDone) begin
			$display("doneStreaming never pulsed, tile copy did not finish");
			errors = errors + 1;
		end
		repeat (3) @(negedge BOARD_CLK);  // room for a stray second pulse
		if (doneCount - startDone != 1)
			reportMismatch("doneStreaming pulses", 1, doneCount - startDone);
		if (busy !== 1'b0)
			reportMismatch("busy", 0, busy);
	endtask

	task automatic runTile(input int x, input int y, input logic [15:0] seed,
		input bit retrigger);
		int   startDone;
		logic backSel;
		startDone = doneCount;
		backSel   = ~doubleBuffer;
		@(negedge BOARD_CLK);
		tileSeed = seed;
		xOffset  = 10'(x);
		yOffset  = 10'(y);
		trigger  = 1'b1;
		@(negedge BOARD_CLK);
		trigger = 1'b0;
		if (retrigger) begin
			if (busy !== 1'b1) begin
				$display("streamer not busy after trigger, retrigger cannot be tested");
				errors = errors + 1;
			end
			xOffset = 10'(frameWidth - tileDim - x);  // mirrored spot, must stay untouched
			yOffset = 10'(frameHeight - tileDim - y);
			trigger = 1'b1;
			@(negedge BOARD_CLK);
			trigger = 1'b0;
		end
		waitDone(startDone);
		commitTile(x, y, seed, backSel);
	endtask

	// full frame scan, optional tile started with the first strobe
	task automatic runScan(input int x, input int y, input logic [15:0] seed);
		int   startDone, waited;
		logic backSel;
		startDone = doneCount;
		backSel   = ~doubleBuffer;
		for (int py = 0; py < frameHeight; py++) begin
			for (int px = 0; px < frameWidth; px++) begin
				@(negedge BOARD_CLK);
				if (seed != 0 && px == 0 && py == 0) begin
					tileSeed = seed;
					xOffset  = 10'(x);
					yOffset  = 10'(y);
					trigger  = 1'b1;
				end
				scanX   = 10'(px);
				scanY   = 10'(py);
				blankN  = 1'b1;
				pixelEn = 1'b1;
				expQ.push_back(expectRgb(shadow[bufferStart(doubleBuffer)
					+ py * frameWidth + px]));
				edgeQ.push_back(cycles + 1);
				@(negedge BOARD_CLK);
				pixelEn = 1'b0;  // free cycle for the streamer
				trigger = 1'b0;
			end
		end
		blankN = 1'b0;
		waited = 0;
		while (expQ.size() > 0 && waited < 8) begin
			@(negedge BOARD_CLK);
			waited++;
		end
		if (expQ.size() > 0) begin
			$display("%0d pixel strobes never produced rgbValid", expQ.size());
			errors = errors + 1;
			expQ.delete();
			edgeQ.delete();
		end
		if (seed != 0) begin
			waitDone(startDone);
			commitTile(x, y, seed, backSel);
		end
	endtask

	// one command per line, lines starting with # skipped
	task automatic loadStim(output bit ok);
		int          fd, x, y, n;
		logic [15:0] seed;
		string       line, op;
		fd = $fopen("test/fbStim.txt", "r");
		ok = (fd != 0);
		while (ok && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				if ($sscanf(line, "%s %d %d %h", op, x, y, seed) == 4) begin
					opQ.push_back(op);
					xQ.push_back(x);
					yQ.push_back(y);
					seedQ.push_back(seed);
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
	endtask

	task automatic reportTest(input string name, input int errStart);
		testsRun++;
		if (errors != errStart) begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", testsRun, name, errors - errStart);
		end else begin
			$display("test %0d %s: ok", testsRun, name);
		end
	endtask

	initial begin
		bit stimOk;
		int gap, errStart;
		scanX        = '0;
		scanY        = '0;
		xOffset      = '0;
		yOffset      = '0;
		pixelEn      = 1'b0;
		blankN       = 1'b0;
		doubleBuffer = 1'b0;
		trigger      = 1'b0;
		tileSeed     = '0;
		for (int i = 0; i < 2 * frameWords; i++) begin
			sram.mem[i] = fillWord(20'(i));
			shadow[i]   = fillWord(20'(i));
		end
		loadStim(stimOk);
		// one extra slot covers reset and the gaps
		cycleLimit = (opQ.size() + 1) * (2 * frameWords + 4 * tileDim * tileDim + 100);
		wait (rstN === 1'b1);
		@(negedge BOARD_CLK);
		errStart = errors;
		if (sramWeN !== 1'b1)
			reportMismatch("sramWeN", 1, sramWeN);
		if (doneStreaming !== 1'b0)
			reportMismatch("doneStreaming", 0, doneStreaming);
		if (busy !== 1'b0)
			reportMismatch("busy", 0, busy);
		if (rgbValid !== 1'b0)
			reportMismatch("rgbValid", 0, rgbValid);
		if ({red, green, blue} !== 24'h0)
			reportMismatch("rgb", 0, {red, green, blue});
		// chip select, output enable and byte enables are tied active
		if (sramCeN !== 1'b0)
			reportMismatch("sramCeN", 0, sramCeN);
		if (sramOeN !== 1'b0)
			reportMismatch("sramOeN", 0, sramOeN);
		if (sramUbN !== 1'b0)
			reportMismatch("sramUbN", 0, sramUbN);
		if (sramLbN !== 1'b0)
			reportMismatch("sramLbN", 0, sramLbN);
		reportTest("reset", errStart);
		if (!stimOk || opQ.size() == 0) begin
			$display("stim file test/fbStim.txt could not be read or holds no commands");
			errors = errors + 1;
		end
		foreach (opQ[i]) begin
			gap = {$random(seedVar)} % 8;
			repeat (gap) @(negedge BOARD_CLK);
			errStart = errors;
			if (opQ[i] == "tile") begin
				runTile(xQ[i], yQ[i], seedQ[i], 1'b0);
			end else if (opQ[i] == "busytrig") begin
				runTile(xQ[i], yQ[i], seedQ[i], 1'b1);
			end else if (opQ[i] == "swap") begin
				@(negedge BOARD_CLK);
				doubleBuffer = ~doubleBuffer;
			end else if (opQ[i] == "scan") begin
				runScan(xQ[i], yQ[i], seedQ[i]);
			end else begin
				$display("unknown stim opcode %s", opQ[i]);
				errors = errors + 1;
			end
			reportTest($sformatf("%s %0d %0d %h", opQ[i], xQ[i], yQ[i], seedQ[i]), errStart);
		end
		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* test/sramModel.sv */
// Behavioural asynchronous SRAM for simulation. Written while weN is low,
// read combinationally onto dq while weN is high. Byte enables not modelled.
// Contents are preloaded by the testbench.

`timescale 1ns/1ps

module sramModel #(
	parameter int depth = 1024
) (
	input  logic [19:0] addr,
	inout  wire  [15:0] dq,
	input  logic        weN,
	input  logic        ceN,
	input  logic        oeN
);

	logic [15:0] mem [0:depth-1];

	// output buffer on during reads only
	assign dq = (!ceN && !oeN && weN === 1'b1) ? mem[addr] : 16'bz;

	// pins all move on one clock edge, look once they have settled
	always @(addr or dq or weN or ceN) begin
		#1;
		if (!ceN && weN === 1'b0 && addr < depth)
			mem[addr] = dq;
	end

endmodule

/* vlog.f */
source/fbPkg.sv
source/sramPort.sv
source/scanoutReader.sv
source/tileStreamer.sv
source/sramArbiter.sv
source/frameBuffer.sv
test/clockGen.sv
test/sramModel.sv
test/frameBufferTb.sv
